// File: fetch_unit.f
+incdir+include
hdl/fetch_pkg.sv
hdl/fetch_redirect.sv
hdl/fetch_cancel.sv
hdl/inst_translate.sv
hdl/if_stage.sv
hdl/fetch_unit.sv
verification/inst_mem_model.sv
verification/fetch_unit_assertions.sv
verification/fetch_unit_tb.sv

// File: Makefile
TOP := fetch_unit_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f fetch_unit.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f fetch_unit.f
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// File: verification/fetch_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defs.svh"

module fetch_unit_tb
    import fetch_pkg::*;
();

    localparam int ROWS       = 11;
    localparam int PER_ROW    = 8;
    localparam int WAIT_LIMIT = 600;

    localparam logic [3:0] KIND_NONE    = 4'b0000;
    localparam logic [3:0] KIND_ERTN    = 4'b0001;
    localparam logic [3:0] KIND_EX      = 4'b0010;
    localparam logic [3:0] KIND_REFETCH = 4'b0100;
    localparam logic [3:0] KIND_BRANCH  = 4'b1000;

    typedef struct packed {
        logic [3:0]   kinds;
        addr_t        br_target;
        addr_t        era;
        addr_t        ex_entry;
        addr_t        wb_pc;
        addr_t        first_pc;
        fetch_excep_t first_excep;
    } redirect_row_t;

    logic         clk;
    logic         resetn;
    logic         inst_sram_req;
    addr_t        inst_sram_addr;
    logic         inst_sram_addr_ok;
    logic         inst_sram_data_ok;
    inst_t        inst_sram_rdata;
    logic         id_allowin;
    logic         br_taken;
    logic         br_stall;
    addr_t        br_target;
    wb_redirect_t wb_redirect;
    logic         if_flush;
    dmw_cfg_t     dmw;
    logic         if_to_id_valid;
    if_to_id_t    if_to_id;

    redirect_row_t rows [ROWS];
    redirect_row_t cur_row;
    int            row_start = 0;
    int            total_transfers = 0;
    int            errors = 0;
    int            assert_fails;
    logic          timed_out = 1'b0;

    fetch_unit fetch_unit_inst (
        .clk               (clk),
        .resetn            (resetn),
        .inst_sram_req     (inst_sram_req),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_addr_ok (inst_sram_addr_ok),
        .inst_sram_data_ok (inst_sram_data_ok),
        .inst_sram_rdata   (inst_sram_rdata),
        .id_allowin        (id_allowin),
        .br_taken          (br_taken),
        .br_stall          (br_stall),
        .br_target         (br_target),
        .wb_redirect       (wb_redirect),
        .if_flush          (if_flush),
        .dmw               (dmw),
        .if_to_id_valid    (if_to_id_valid),
        .if_to_id          (if_to_id)
    );

    inst_mem_model mem_inst (
        .clk     (clk),
        .resetn  (resetn),
        .req     (inst_sram_req),
        .addr    (inst_sram_addr),
        .addr_ok (inst_sram_addr_ok),
        .data_ok (inst_sram_data_ok),
        .rdata   (inst_sram_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // decode back-pressure
    initial begin
        id_allowin = 1'b0;
        forever begin
            @(negedge clk);
            id_allowin = ($urandom % 4) != 0;
        end
    end

    // the window maps 0x00000000 to 0x1fffffff onto itself
    function automatic inst_t expected_inst(input addr_t pc, input fetch_excep_t excep);
        if (excep.adef || excep.tlbr) begin
            return '0;
        end
        return pc ^ 32'hA5A5_0000;
    endfunction

    task automatic check_transfer();
        addr_t exp_pc;
        inst_t exp_inst;
        exp_pc   = cur_row.first_pc + 32'(4 * (total_transfers - row_start));
        exp_inst = expected_inst(exp_pc, cur_row.first_excep);
        assert (if_to_id.pc == exp_pc) else begin
            $display("MISMATCH if_to_id.pc got %h expected %h", if_to_id.pc, exp_pc);
            errors++;
        end
        assert (if_to_id.excep == cur_row.first_excep) else begin
            $display("MISMATCH if_to_id.excep got %h expected %h", if_to_id.excep,
                     cur_row.first_excep);
            errors++;
        end
        assert (if_to_id.inst == exp_inst) else begin
            $display("MISMATCH if_to_id.inst got %h expected %h", if_to_id.inst, exp_inst);
            errors++;
        end
    endtask

    always @(posedge clk) begin
        if (resetn) begin
            // unmapped or misaligned targets must never reach memory
            if (inst_sram_req) begin
                assert (inst_sram_addr[1:0] == 2'b00 && inst_sram_addr[31:29] == 3'b000)
                else begin
                    $display("memory request made for a faulting address %h", inst_sram_addr);
                    errors++;
                end
            end
            if (if_flush) begin
                assert (!(if_to_id_valid && id_allowin)) else begin
                    $display("transfer to decode happened while if_flush was high");
                    errors++;
                end
            end
            if (if_to_id_valid && id_allowin) begin
                check_transfer();
                total_transfers++;
            end
        end
    end

    task automatic hold_flush(input int cycles);
        @(negedge clk);
        if_flush = 1'b1;
        repeat (cycles) @(negedge clk);
        if_flush = 1'b0;
    endtask

    task automatic apply_redirect(input redirect_row_t row);
        @(negedge clk);
        cur_row                   = row;
        row_start                 = total_transfers;
        br_taken                  = row.kinds[3];
        br_target                 = row.br_target;
        wb_redirect.ertn_valid    = row.kinds[0];
        wb_redirect.ex_valid      = row.kinds[1];
        wb_redirect.refetch_valid = row.kinds[2];
        wb_redirect.era           = row.era;
        wb_redirect.ex_entry      = row.ex_entry;
        wb_redirect.wb_pc         = row.wb_pc;
        @(negedge clk);
        br_taken                  = 1'b0;
        wb_redirect.ertn_valid    = 1'b0;
        wb_redirect.ex_valid      = 1'b0;
        wb_redirect.refetch_valid = 1'b0;
    endtask

    task automatic wait_for_transfers(input int count);
        int waited;
        waited = 0;
        while ((total_transfers - row_start) < count && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if ((total_transfers - row_start) < count) begin
            $display("timeout: only %0d of %0d transfers arrived",
                     total_transfers - row_start, count);
            timed_out = 1'b1;
        end
    endtask

    initial begin
        void'($urandom(32'h59eb));
        resetn      = 1'b0;
        br_taken    = 1'b0;
        br_stall    = 1'b0;
        br_target   = '0;
        wb_redirect = '0;
        if_flush    = 1'b0;
        dmw         = '{da: 1'b0, plen: 1'b1, vseg: 3'b000, pseg: 3'b000};

        rows[0]  = '{KIND_NONE, '0, '0, '0, '0, `FETCH_RESET_PC, 2'b00};
        rows[1]  = '{KIND_BRANCH, 32'h1c00_1000, '0, '0, '0, 32'h1c00_1000, 2'b00};
        rows[2]  = '{KIND_ERTN, '0, 32'h1c00_2000, '0, '0, 32'h1c00_2000, 2'b00};
        rows[3]  = '{KIND_EX, '0, '0, 32'h1c00_3000, '0, 32'h1c00_3000, 2'b00};
        rows[4]  = '{KIND_REFETCH, '0, '0, '0, 32'h1c00_4000, 32'h1c00_4004, 2'b00};
        rows[5]  = '{KIND_ERTN | KIND_EX, '0, 32'h1c00_5000, 32'h1c00_5800, '0,
                     32'h1c00_5000, 2'b00};
        rows[6]  = '{KIND_EX | KIND_REFETCH, '0, '0, 32'h1c00_6000, 32'h1c00_6800,
                     32'h1c00_6000, 2'b00};
        rows[7]  = '{KIND_REFETCH | KIND_BRANCH, 32'h1c00_7800, '0, '0, 32'h1c00_7100,
                     32'h1c00_7104, 2'b00};
        // misaligned target and one outside the window
        rows[8]  = '{KIND_BRANCH, 32'h1c00_8002, '0, '0, '0, 32'h1c00_8002, 2'b10};
        rows[9]  = '{KIND_BRANCH, 32'h2000_0000, '0, '0, '0, 32'h2000_0000, 2'b01};
        rows[10] = '{KIND_BRANCH, 32'h1c00_9000, '0, '0, '0, 32'h1c00_9000, 2'b00};
        cur_row  = rows[0];

        repeat (16) @(negedge clk);
        resetn = 1'b1;

        for (int r = 0; r < ROWS && !timed_out; r++) begin
            if (r > 0) begin
                hold_flush(2 + int'($urandom % 3));
                repeat ($urandom % 4) @(negedge clk);
                apply_redirect(rows[r]);
            end
            wait_for_transfers(PER_ROW);
        end

        assert_fails = fetch_unit_inst.fetch_unit_assertions_inst.failures;
        $display("errors=%0d assertion_failures=%0d transfers=%0d timeout=%0d",
                 errors, assert_fails, total_transfers, timed_out);
        if (errors == 0 && assert_fails == 0 && !timed_out) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/fetch_unit_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit_assertions
    import fetch_pkg::*;
(
    input logic         clk,
    input logic         resetn,
    input logic         inst_sram_req,
    input addr_t        inst_sram_addr,
    input logic         inst_sram_addr_ok,
    input logic         inst_sram_data_ok,
    input logic         id_allowin,
    input logic         br_taken,
    input wb_redirect_t wb_redirect,
    input logic         if_flush,
    input logic         if_to_id_valid,
    input if_to_id_t    if_to_id
);

    int         failures = 0;
    logic [7:0] owed;
    logic       redirect_any;

    assign redirect_any = br_taken | wb_redirect.ertn_valid | wb_redirect.ex_valid
                        | wb_redirect.refetch_valid;

    // accepted addresses minus responses seen so far
    always_ff @(posedge clk) begin
        if (!resetn) begin
            owed <= '0;
        end else begin
            owed <= owed + {7'd0, inst_sram_req & inst_sram_addr_ok}
                         - {7'd0, inst_sram_data_ok};
        end
    end

    reset_quiet: assert property (@(posedge clk)
        (!resetn && $past(!resetn)) |-> (!inst_sram_req && !if_to_id_valid))
        else begin
            $error("request or output valid during reset");
            failures++;
        end

    aligned_req: assert property (@(posedge clk) disable iff (!resetn)
        inst_sram_req |-> (inst_sram_addr[1:0] == 2'b00))
        else begin
            $error("memory request for a misaligned address");
            failures++;
        end

    hold_output: assert property (@(posedge clk) disable iff (!resetn)
        (if_to_id_valid && !id_allowin)
            |=> (redirect_any || if_flush || (if_to_id_valid && $stable(if_to_id))))
        else begin
            $error("if_to_id changed or dropped while decode stalled");
            failures++;
        end

    no_extra_data: assert property (@(posedge clk) disable iff (!resetn)
        inst_sram_data_ok |-> (owed != 8'd0))
        else begin
            $error("data_ok without an outstanding address");
            failures++;
        end

endmodule

bind fetch_unit fetch_unit_assertions fetch_unit_assertions_inst (
    .clk               (clk),
    .resetn            (resetn),
    .inst_sram_req     (inst_sram_req),
    .inst_sram_addr    (inst_sram_addr),
    .inst_sram_addr_ok (inst_sram_addr_ok),
    .inst_sram_data_ok (inst_sram_data_ok),
    .id_allowin        (id_allowin),
    .br_taken          (br_taken),
    .wb_redirect       (wb_redirect),
    .if_flush          (if_flush),
    .if_to_id_valid    (if_to_id_valid),
    .if_to_id          (if_to_id)
);

`default_nettype wire

// File: verification/inst_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module inst_mem_model
    import fetch_pkg::*;
(
    input  logic  clk,
    input  logic  resetn,
    input  logic  req,
    input  addr_t addr,
    output logic  addr_ok,
    output logic  data_ok,
    output inst_t rdata
);

    addr_t pend_addr [$];
    int    pend_due  [$];
    int    cycle    = 0;
    int    last_due = 0;

    // accept on the rising edge, responses stay in order
    always @(posedge clk) begin
        int due;
        cycle++;
        if (!resetn) begin
            pend_addr.delete();
            pend_due.delete();
        end else begin
            if (data_ok) begin
                void'(pend_addr.pop_front());
                void'(pend_due.pop_front());
            end
            if (req && addr_ok) begin
                // latency of 1 to 4 cycles, at most one response per cycle
                due = cycle + int'($urandom % 4);
                if (due <= last_due) begin
                    due = last_due + 1;
                end
                last_due = due;
                pend_addr.push_back(addr);
                pend_due.push_back(due);
            end
        end
    end

    initial begin
        addr_ok = 1'b0;
        data_ok = 1'b0;
        rdata   = '0;
        forever begin
            @(negedge clk);
            addr_ok = resetn && (($urandom % 4) != 0);
            data_ok = (pend_due.size() != 0) && (pend_due[0] <= cycle);
            rdata   = data_ok ? (pend_addr[0] ^ 32'hA5A5_0000) : 32'hFFFF_FFFF;
        end
    end

endmodule

`default_nettype wire

// File: hdl/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit
    import fetch_pkg::*;
(
    input  logic         clk,
    input  logic         resetn,
    output logic         inst_sram_req,
    output addr_t        inst_sram_addr,
    input  logic         inst_sram_addr_ok,
    input  logic         inst_sram_data_ok,
    input  inst_t        inst_sram_rdata,
    input  logic         id_allowin,
    input  logic         br_taken,
    input  logic         br_stall,
    input  addr_t        br_target,
    input  wb_redirect_t wb_redirect,
    input  logic         if_flush,
    input  dmw_cfg_t     dmw,
    output logic         if_to_id_valid,
    output if_to_id_t    if_to_id
);

    addr_t        next_pc;
    logic         redirect_now;
    logic         issue;
    fetch_excep_t next_excep;
    logic         waiting;
    logic         discard;

    fetch_redirect u_redirect (
        .clk          (clk),
        .resetn       (resetn),
        .br_taken     (br_taken),
        .br_target    (br_target),
        .wb_redirect  (wb_redirect),
        .pc           (if_to_id.pc),
        .issue        (issue),
        .next_pc      (next_pc),
        .redirect_now (redirect_now)
    );

    inst_translate u_translate (
        .va    (next_pc),
        .dmw   (dmw),
        .pa    (inst_sram_addr),
        .excep (next_excep)
    );

    fetch_cancel u_cancel (
        .clk          (clk),
        .resetn       (resetn),
        .redirect_now (redirect_now),
        .waiting      (waiting),
        .data_ok      (inst_sram_data_ok),
        .discard      (discard)
    );

    if_stage u_if (
        .clk            (clk),
        .resetn         (resetn),
        .next_pc        (next_pc),
        .next_excep     (next_excep),
        .redirect_now   (redirect_now),
        .br_stall       (br_stall),
        .if_flush       (if_flush),
        .addr_ok        (inst_sram_addr_ok),
        .data_ok        (inst_sram_data_ok),
        .rdata          (inst_sram_rdata),
        .discard        (discard),
        .id_allowin     (id_allowin),
        .req            (inst_sram_req),
        .issue          (issue),
        .waiting        (waiting),
        .if_to_id_valid (if_to_id_valid),
        .if_to_id       (if_to_id)
    );

endmodule

`default_nettype wire

// File: hdl/if_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defs.svh"

module if_stage
    import fetch_pkg::*;
(
    input  logic         clk,
    input  logic         resetn,
    input  addr_t        next_pc,
    input  fetch_excep_t next_excep,
    input  logic         redirect_now,
    input  logic         br_stall,
    input  logic         if_flush,
    input  logic         addr_ok,
    input  logic         data_ok,
    input  inst_t        rdata,
    input  logic         discard,
    input  logic         id_allowin,
    output logic         req,
    output logic         issue,
    output logic         waiting,
    output logic         if_to_id_valid,
    output if_to_id_t    if_to_id
);

    logic         fetch_started;
    logic         if_valid;
    addr_t        if_pc;
    fetch_excep_t if_excep;
    inst_t        buf_inst;
    logic         buf_valid;

    logic         next_fault;
    logic         if_fault;
    logic         live_data;
    logic         can_fetch;
    logic         fault_entry;
    logic         if_ready_go;
    logic         if_allowin;
    logic         out_fire;

    // first request goes out one cycle after reset is released
    always_ff @(posedge clk) begin
        if (!resetn) begin
            fetch_started <= 1'b0;
        end else begin
            fetch_started <= 1'b1;
        end
    end

    assign next_fault = next_excep.adef | next_excep.tlbr;
    assign if_fault   = if_excep.adef | if_excep.tlbr;
    assign live_data  = data_ok & ~discard;

    assign if_ready_go = if_fault | buf_valid | live_data;
    assign if_to_id_valid = if_valid & if_ready_go & ~if_flush & ~redirect_now;
    assign out_fire    = if_to_id_valid & id_allowin;
    // entry leaves IF only through a real transfer
    assign if_allowin  = ~if_valid | out_fire;

    assign can_fetch   = fetch_started & if_allowin & ~br_stall;
    assign req         = can_fetch & ~next_fault;
    // faulting address enters IF without touching memory
    assign fault_entry = can_fetch & next_fault;
    assign issue       = (req & addr_ok) | fault_entry;

    assign waiting     = if_valid & ~if_ready_go;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            if_valid <= 1'b0;
        end else if (if_allowin) begin
            if_valid <= issue;
        end else if (redirect_now) begin
            if_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            if_pc    <= `FETCH_PC_INIT;
            if_excep <= '0;
        end else if (if_allowin && issue) begin
            if_pc    <= next_pc;
            if_excep <= next_excep;
        end
    end

    // hold the instruction while decode is stalled
    always_ff @(posedge clk) begin
        if (!resetn) begin
            buf_valid <= 1'b0;
        end else if (out_fire || redirect_now) begin
            buf_valid <= 1'b0;
        end else if (if_valid && !buf_valid && live_data) begin
            buf_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (if_valid && !buf_valid && live_data) begin
            buf_inst <= rdata;
        end
    end

    always_comb begin
        if_to_id.pc    = if_pc;
        if_to_id.excep = if_excep;
        if (if_fault) begin
            if_to_id.inst = '0;
        end else if (live_data) begin
            if_to_id.inst = rdata;
        end else begin
            if_to_id.inst = buf_inst;
        end
    end

endmodule

`default_nettype wire

// File: hdl/inst_translate.sv
`timescale 1ns/1ps
`default_nettype none

module inst_translate
    import fetch_pkg::*;
(
    input  addr_t        va,
    input  dmw_cfg_t     dmw,
    output addr_t        pa,
    output fetch_excep_t excep
);

    logic win_hit;

    assign win_hit = dmw.plen && (va[31:29] == dmw.vseg);

    always_comb begin
        excep.adef = |va[1:0];
        excep.tlbr = 1'b0;
        if (dmw.da) begin
            pa = va;
        end else if (win_hit) begin
            pa = {dmw.pseg, va[28:0]};
        end else begin
            // nothing maps it, address goes nowhere
            pa         = va;
            excep.tlbr = 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: hdl/fetch_cancel.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_cancel
    import fetch_pkg::*;
(
    input  logic clk,
    input  logic resetn,
    input  logic redirect_now,
    input  logic waiting,
    input  logic data_ok,
    output logic discard
);

    cancel_cnt_t cnt;
    logic        inc;
    logic        dec;

    // entry killed while its response is still in flight
    assign inc = redirect_now & waiting;
    assign dec = discard & data_ok;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            cnt <= '0;
        end else begin
            case ({inc, dec})
                2'b10: cnt <= cnt + 1'b1;
                2'b01: cnt <= cnt - 1'b1;
                default: cnt <= cnt;
            endcase
        end
    end

    assign discard = |cnt;

endmodule

`default_nettype wire

// File: hdl/fetch_redirect.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_redirect
    import fetch_pkg::*;
(
    input  logic         clk,
    input  logic         resetn,
    input  logic         br_taken,
    input  addr_t        br_target,
    input  wb_redirect_t wb_redirect,
    input  addr_t        pc,
    input  logic         issue,
    output addr_t        next_pc,
    output logic         redirect_now
);

    // index order is priority order and 0 wins
    localparam int KINDS = 4;

    logic [KINDS-1:0] pulse;
    addr_t            tgt_in [KINDS];
    logic [KINDS-1:0] pend;
    addr_t            tgt_q  [KINDS];

    always_comb begin
        pulse = {br_taken, wb_redirect.refetch_valid, wb_redirect.ex_valid,
                 wb_redirect.ertn_valid};
        tgt_in[0] = wb_redirect.era;
        tgt_in[1] = wb_redirect.ex_entry;
        tgt_in[2] = wb_redirect.wb_pc + 32'd4;
        tgt_in[3] = br_target;
    end

    assign redirect_now = |pulse;

    // hold a redirect until the next address is taken
    always_ff @(posedge clk) begin
        if (!resetn) begin
            pend <= '0;
        end else begin
            for (int k = 0; k < KINDS; k++) begin
                if (pulse[k] && !issue) begin
                    pend[k] <= 1'b1;
                end else if (issue) begin
                    pend[k] <= 1'b0;
                end
            end
        end
    end

    // an older held target is kept over a newer pulse of its kind
    always_ff @(posedge clk) begin
        for (int k = 0; k < KINDS; k++) begin
            if (pulse[k] && !issue && !pend[k]) begin
                tgt_q[k] <= tgt_in[k];
            end
        end
    end

    // walk from lowest priority up so the winner is written last
    // a held target beats a new pulse of its own kind
    always_comb begin
        next_pc = pc + 32'd4;
        for (int k = KINDS - 1; k >= 0; k--) begin
            if (pulse[k]) begin
                next_pc = tgt_in[k];
            end
            if (pend[k]) begin
                next_pc = tgt_q[k];
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/fetch_pkg.sv
`default_nettype none

`include "fetch_defs.svh"

package fetch_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] inst_t;
    typedef logic [`CANCEL_CNT_W-1:0] cancel_cnt_t;

    typedef struct packed {
        logic adef;
        logic tlbr;
    } fetch_excep_t;

    // writeback redirect bundle
    typedef struct packed {
        logic  ertn_valid;
        logic  ex_valid;
        logic  refetch_valid;
        addr_t era;
        addr_t ex_entry;
        addr_t wb_pc;
    } wb_redirect_t;

    // one direct-mapped window plus direct mode
    typedef struct packed {
        logic       da;
        logic       plen;
        logic [2:0] vseg;
        logic [2:0] pseg;
    } dmw_cfg_t;

    typedef struct packed {
        addr_t        pc;
        inst_t        inst;
        fetch_excep_t excep;
    } if_to_id_t;

endpackage

`default_nettype wire

// File: include/fetch_defs.svh
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// first fetch address after reset
`define FETCH_RESET_PC 32'h1c00_0000

// PC register holds the address before the first fetch
`define FETCH_PC_INIT (`FETCH_RESET_PC - 32'd4)

// responses still owed to a dead path
`define CANCEL_CNT_W 4

`endif
